// File: sources.f
+incdir+.
wo_pkg.sv
wo_request_queue.sv
wo_tag_tracker.sv
wo_order_stage.sv
wo_write_order_shim.sv
tb_write_order_assertions.sv
tb_write_order.sv

// File: Makefile
# Verilator build and run for the write-ordering shim

TOP = tb_write_order

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then \
		echo "Run failed, see sim.log"; exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" sim.log; then \
		echo "Run ended without a pass, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: tb_write_order.sv
// ========================================
// Testbench for the write-ordering shim
// Clock and reset, random request source,
// memory responder, completion count and
// the cycle limit
// ========================================

`timescale 1ns/1ps

`include "wo_params.svh"

module tb_write_order
    import wo_pkg::*;
();

    localparam int n_requests = 300;

    // Heavy conflicts cost roughly ten cycles per request.
    // The limit leaves a wide margin above that
    localparam int cycle_limit = 20000;

    logic    clk;
    logic    reset_n;
    wo_req_t req;
    logic    req_almost_full;
    wo_req_t mem_req;
    logic    mem_rd_full;
    logic    mem_wr_full;
    wo_rsp_t mem_rsp;
    wo_rsp_t afu_rsp;

    int seed = 20182;
    int expected;
    int received;
    int cycles;

    // Four addresses only, so reads and writes collide often
    logic [`WO_ADDR_BITS-1:0] addr_set [4] = '{32'h0000_1000, 32'h0000_1040,
                                              32'h0000_2000, 32'h0003_1000};

    wo_write_order_shim uut (
        .clk             (clk),
        .reset_n         (reset_n),
        .req             (req),
        .req_almost_full (req_almost_full),
        .mem_req         (mem_req),
        .mem_rd_full     (mem_rd_full),
        .mem_wr_full     (mem_wr_full),
        .mem_rsp         (mem_rsp),
        .afu_rsp         (afu_rsp)
    );

    // ========================================
    // Clock and reset
    // ========================================

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        reset_n = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        reset_n = 1'b1;
    end

    // Read only, write only, or both halves in one slot.
    // Mdata is even for reads and odd for writes, so every value is unique
    task automatic build_request(input int n, output wo_req_t r);
        int kind;
        r = '0;
        kind = 1 + int'($unsigned($random(seed)) % 3);
        if (kind != 2)
        begin
            r.rd_valid = 1'b1;
            r.rd_addr = addr_set[2'($random(seed) & 3)];
            r.rd_mdata = 16'(2 * n);
            r.rd_check_order = (($random(seed) & 7) != 0);
        end
        if (kind != 1)
        begin
            r.wr_valid = 1'b1;
            r.wr_addr = addr_set[2'($random(seed) & 3)];
            r.wr_mdata = 16'(2 * n + 1);
            r.wr_data = {$random(seed), $random(seed)};
            r.wr_check_order = (($random(seed) & 7) != 0);
        end
    endtask

    // ========================================
    // Request source and end of run
    // ========================================

    initial
    begin
        wo_req_t next_req;
        int      sent;
        req = '0;
        expected = 0;
        sent = 0;
        wait (reset_n);
        while (sent < n_requests)
        begin
            @(posedge clk);
            #2;
            req = '0;
            // Almost-full is registered, so the source reacts in the same cycle
            if (!req_almost_full && (($random(seed) & 3) != 0))
            begin
                build_request(sent, next_req);
                req = next_req;
                expected += int'(next_req.rd_valid) + int'(next_req.wr_valid);
                sent++;
            end
        end
        @(posedge clk);
        #2;
        req = '0;
        wait (received >= expected);
        // A few idle cycles catch any response beyond the expected count
        repeat (20) @(posedge clk);
        if (received != expected)
        begin
            $display("ERROR at time %0t: received is %0d, expected %0d",
                     $time, received, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "response count mismatch");
        end
        else
        begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

    // ========================================
    // Memory responder
    // ========================================

    // Issued mdata is taken at the falling edge, where mem_req is settled.
    // One pending entry per channel is answered at random each cycle
    initial
    begin
        logic [`WO_MDATA_BITS-1:0] rd_pending [$];
        logic [`WO_MDATA_BITS-1:0] wr_pending [$];
        wo_rsp_t                   rsp_next;
        logic                      rd_full_next;
        logic                      wr_full_next;
        int                        pick;
        mem_rsp = '0;
        mem_rd_full = 1'b0;
        mem_wr_full = 1'b0;
        forever
        begin
            @(negedge clk);
            if (mem_req.rd_valid)
            begin
                rd_pending.push_back(mem_req.rd_mdata);
            end
            if (mem_req.wr_valid)
            begin
                wr_pending.push_back(mem_req.wr_mdata);
            end
            rsp_next = '0;
            if (rd_pending.size() > 0 && ($random(seed) & 1) != 0)
            begin
                pick = int'($unsigned($random(seed)) % rd_pending.size());
                rsp_next.rd_valid = 1'b1;
                rsp_next.rd_mdata = rd_pending[pick];
                rsp_next.rd_data = {$random(seed), $random(seed)};
                rd_pending.delete(pick);
            end
            if (wr_pending.size() > 0 && ($random(seed) & 1) != 0)
            begin
                pick = int'($unsigned($random(seed)) % wr_pending.size());
                rsp_next.wr_valid = 1'b1;
                rsp_next.wr_mdata = wr_pending[pick];
                wr_pending.delete(pick);
            end
            // Short bursts of back-pressure on each channel
            rd_full_next = (($random(seed) & 7) == 0);
            wr_full_next = (($random(seed) & 7) == 0);
            @(posedge clk);
            #2;
            mem_rsp = rsp_next;
            mem_rd_full = rd_full_next;
            mem_wr_full = wr_full_next;
        end
    end

    // ========================================
    // Response count, check monitor, timeout
    // ========================================

    initial
    begin
        received = 0;
        cycles = 0;
        forever
        begin
            @(negedge clk);
            cycles++;
            if (reset_n)
            begin
                received += int'(afu_rsp.rd_valid) + int'(afu_rsp.wr_valid);
            end
            if (uut.checks.violations != 0)
            begin
                $display("ERROR: a bound check on the shim failed at time %0t", $time);
                $display("SIMULATION FAILED");
                $fatal(1, "bound check failed");
            end
            else if (cycles >= cycle_limit)
            begin
                $display("ERROR: the run did not complete within %0d cycles", cycle_limit);
                $display("SIMULATION FAILED");
                $fatal(1, "timeout");
            end
        end
    end

endmodule

// File: tb_write_order_assertions.sv
// ========================================
// Concurrent checks on the shim top level
// Side models of accepted order, live tags
// and expected responses, bound to the DUT
// ========================================

`timescale 1ns/1ps

`include "wo_params.svh"

module tb_write_order_assertions
    import wo_pkg::*;
(
    input logic    clk,
    input logic    reset_n,
    input wo_req_t req,
    input logic    req_almost_full,
    input wo_req_t mem_req,
    input logic    mem_rd_full,
    input logic    mem_wr_full,
    input wo_rsp_t mem_rsp,
    input wo_rsp_t afu_rsp
);

    localparam int rd_tag_bits = $bits(wo_rd_tag_t);
    localparam int wr_tag_bits = $bits(wo_wr_tag_t);

    // Accepted halves in arrival order, per channel
    logic [`WO_ADDR_BITS-1:0]  rd_addr_log [1024];
    logic [`WO_MDATA_BITS-1:0] rd_mdata_log [1024];
    logic                      rd_order_log [1024];
    logic [`WO_ADDR_BITS-1:0]  wr_addr_log [1024];
    logic [`WO_MDATA_BITS-1:0] wr_mdata_log [1024];
    logic [`WO_DATA_BITS-1:0]  wr_data_log [1024];
    logic                      wr_order_log [1024];
    logic [9:0]                rd_in;
    logic [9:0]                rd_out;
    logic [9:0]                wr_in;
    logic [9:0]                wr_out;

    // Writes that share a slot and an address with a read, and that read's index
    logic                      wr_pair_log [1024];
    logic [9:0]                wr_pair_idx_log [1024];
    logic [9:0]                rd_ahead;

    // Outstanding tags with their address and original mdata
    logic [`WO_RD_TAGS-1:0]    rd_live;
    logic [`WO_WR_TAGS-1:0]    wr_live;
    logic [`WO_ADDR_BITS-1:0]  rd_live_addr [`WO_RD_TAGS];
    logic [`WO_ADDR_BITS-1:0]  wr_live_addr [`WO_WR_TAGS];
    logic [`WO_MDATA_BITS-1:0] rd_orig [`WO_RD_TAGS];
    logic [`WO_MDATA_BITS-1:0] wr_orig [`WO_WR_TAGS];

    // Response due in this cycle, captured from mem_rsp one edge earlier
    logic                      exp_rd_valid;
    logic                      exp_wr_valid;
    logic [`WO_MDATA_BITS-1:0] exp_rd_mdata;
    logic [`WO_MDATA_BITS-1:0] exp_wr_mdata;
    logic [`WO_DATA_BITS-1:0]  exp_rd_data;

    logic       seen_req;
    logic       rd_conflict;
    logic       wr_conflict;
    logic       idle_ok;
    logic       order_ok;
    logic       flow_ok;
    logic       conflict_ok;
    logic       rsp_ok;
    wo_rd_tag_t rd_tag;
    wo_wr_tag_t wr_tag;
    wo_rd_tag_t rsp_rd_tag;
    wo_wr_tag_t rsp_wr_tag;
    int         violations;

    assign rd_tag = mem_req.rd_mdata[rd_tag_bits-1:0];
    assign wr_tag = mem_req.wr_mdata[wr_tag_bits-1:0];
    assign rsp_rd_tag = mem_rsp.rd_mdata[rd_tag_bits-1:0];
    assign rsp_wr_tag = mem_rsp.wr_mdata[wr_tag_bits-1:0];

    // Reads issued so far beyond the paired read of the write at the head.
    // A value from 1 up means that read left in an earlier cycle
    assign rd_ahead = rd_out - wr_pair_idx_log[wr_out];

    // Ordering is by exact address here.
    // A hash filter may block more often but never less
    always_comb
    begin
        rd_conflict = 1'b0;
        wr_conflict = 1'b0;
        for (int i = 0; i < `WO_WR_TAGS; i++)
        begin
            if (wr_live[i] && wr_live_addr[i] == mem_req.rd_addr)
            begin
                rd_conflict = 1'b1;
            end
            if (wr_live[i] && wr_live_addr[i] == mem_req.wr_addr)
            begin
                wr_conflict = 1'b1;
            end
        end
        for (int i = 0; i < `WO_RD_TAGS; i++)
        begin
            if (rd_live[i] && rd_live_addr[i] == mem_req.wr_addr)
            begin
                wr_conflict = 1'b1;
            end
        end
    end

    assign idle_ok = seen_req || !(mem_req.rd_valid || mem_req.wr_valid ||
                     afu_rsp.rd_valid || afu_rsp.wr_valid || req_almost_full);
    assign order_ok = (!mem_req.rd_valid ||
                       (rd_out != rd_in && mem_req.rd_addr == rd_addr_log[rd_out] &&
                        mem_req.rd_check_order == rd_order_log[rd_out])) &&
                      (!mem_req.wr_valid ||
                       (wr_out != wr_in && mem_req.wr_addr == wr_addr_log[wr_out] &&
                        mem_req.wr_data == wr_data_log[wr_out] &&
                        mem_req.wr_check_order == wr_order_log[wr_out] &&
                        (!wr_pair_log[wr_out] || (rd_ahead != '0 && !rd_ahead[9]))));
    assign flow_ok = !(mem_req.rd_valid && (mem_rd_full || rd_live[rd_tag])) &&
                     !(mem_req.wr_valid && (mem_wr_full || wr_live[wr_tag]));
    assign conflict_ok = !(mem_req.rd_valid && rd_order_log[rd_out] && rd_conflict) &&
                         !(mem_req.wr_valid && wr_order_log[wr_out] && wr_conflict);
    assign rsp_ok = (afu_rsp.rd_valid == exp_rd_valid) &&
                    (afu_rsp.wr_valid == exp_wr_valid) &&
                    (!exp_rd_valid || (afu_rsp.rd_mdata == exp_rd_mdata &&
                                       afu_rsp.rd_data == exp_rd_data)) &&
                    (!exp_wr_valid || afu_rsp.wr_mdata == exp_wr_mdata);

    // ========================================
    // Side models
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            seen_req <= 1'b0;
            rd_in <= '0;
            rd_out <= '0;
            wr_in <= '0;
            wr_out <= '0;
            rd_live <= '0;
            wr_live <= '0;
            exp_rd_valid <= 1'b0;
            exp_wr_valid <= 1'b0;
            violations <= 0;
        end
        else
        begin
            if (req.rd_valid || req.wr_valid)
            begin
                seen_req <= 1'b1;
            end
            if (req.rd_valid)
            begin
                rd_addr_log[rd_in] <= req.rd_addr;
                rd_mdata_log[rd_in] <= req.rd_mdata;
                rd_order_log[rd_in] <= req.rd_check_order;
                rd_in <= rd_in + 1'b1;
            end
            if (req.wr_valid)
            begin
                wr_addr_log[wr_in] <= req.wr_addr;
                wr_mdata_log[wr_in] <= req.wr_mdata;
                wr_data_log[wr_in] <= req.wr_data;
                wr_order_log[wr_in] <= req.wr_check_order;
                // Such a write must leave after the read of its own slot
                wr_pair_log[wr_in] <= req.rd_valid && (req.rd_addr == req.wr_addr);
                wr_pair_idx_log[wr_in] <= rd_in;
                wr_in <= wr_in + 1'b1;
            end
            // A response frees its tag, an issue claims a different one
            if (mem_rsp.rd_valid)
            begin
                rd_live[rsp_rd_tag] <= 1'b0;
            end
            if (mem_rsp.wr_valid)
            begin
                wr_live[rsp_wr_tag] <= 1'b0;
            end
            if (mem_req.rd_valid)
            begin
                rd_live[rd_tag] <= 1'b1;
                rd_live_addr[rd_tag] <= mem_req.rd_addr;
                rd_orig[rd_tag] <= rd_mdata_log[rd_out];
                rd_out <= rd_out + 1'b1;
            end
            if (mem_req.wr_valid)
            begin
                wr_live[wr_tag] <= 1'b1;
                wr_live_addr[wr_tag] <= mem_req.wr_addr;
                wr_orig[wr_tag] <= wr_mdata_log[wr_out];
                wr_out <= wr_out + 1'b1;
            end
            exp_rd_valid <= mem_rsp.rd_valid;
            exp_wr_valid <= mem_rsp.wr_valid;
            exp_rd_mdata <= rd_orig[rsp_rd_tag];
            exp_wr_mdata <= wr_orig[rsp_wr_tag];
            exp_rd_data <= mem_rsp.rd_data;
            if (!(idle_ok && order_ok && flow_ok && conflict_ok && rsp_ok))
            begin
                violations <= violations + 1;
            end
        end
    end

    // ========================================
    // Assertions
    // ========================================

    idle_after_reset: assert property (@(posedge clk) disable iff (!reset_n) idle_ok)
        else $error("Outputs active before the first accepted request");

    issue_in_order: assert property (@(posedge clk) disable iff (!reset_n) order_ok)
        else $error("Issued request out of accepted order, altered, or not split");

    issue_flow: assert property (@(posedge clk) disable iff (!reset_n) flow_ok)
        else $error("Issue against a full channel or with an outstanding tag");

    issue_ordered: assert property (@(posedge clk) disable iff (!reset_n) conflict_ok)
        else $error("Ordered request issued over an outstanding same-address request");

    response_restore: assert property (@(posedge clk) disable iff (!reset_n) rsp_ok)
        else $error("Response late, missing or with wrong mdata or data");

endmodule

bind wo_write_order_shim tb_write_order_assertions checks (
    .clk             (clk),
    .reset_n         (reset_n),
    .req             (req),
    .req_almost_full (req_almost_full),
    .mem_req         (mem_req),
    .mem_rd_full     (mem_rd_full),
    .mem_wr_full     (mem_wr_full),
    .mem_rsp         (mem_rsp),
    .afu_rsp         (afu_rsp)
);

// File: wo_write_order_shim.sv
// ========================================
// Top level of the write-ordering shim
// Request queue feeding the order stage,
// which faces the memory port
// ========================================

`timescale 1ns/1ps

module wo_write_order_shim
    import wo_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,

    // Request source side
    input  wo_req_t req,
    output logic    req_almost_full,

    // Memory request side, with per-channel full levels
    output wo_req_t mem_req,
    input  logic    mem_rd_full,
    input  logic    mem_wr_full,

    // Responses from memory and back to the source
    input  wo_rsp_t mem_rsp,
    output wo_rsp_t afu_rsp
);

    // Queue head as seen by the order stage
    wo_req_t queue_head;
    logic    queue_head_valid;
    logic    queue_pop;

    // Absorbs requests while the order stage holds a blocked slot
    wo_request_queue queue (
        .clk         (clk),
        .reset_n     (reset_n),
        .req         (req),
        .pop         (queue_pop),
        .head        (queue_head),
        .head_valid  (queue_head_valid),
        .almost_full (req_almost_full)
    );

    // Owns the issue decision and the response restore
    wo_order_stage order (
        .clk         (clk),
        .reset_n     (reset_n),
        .head        (queue_head),
        .head_valid  (queue_head_valid),
        .pop         (queue_pop),
        .mem_req     (mem_req),
        .mem_rd_full (mem_rd_full),
        .mem_wr_full (mem_wr_full),
        .mem_rsp     (mem_rsp),
        .afu_rsp     (afu_rsp)
    );

endmodule

// File: wo_order_stage.sv
// ========================================
// Ordering stage of the write-ordering shim
// Issue slot with same-address split, the
// lockstep blocking decision, tag swap on
// issue and mdata restore on response
// ========================================

`timescale 1ns/1ps

`include "wo_params.svh"

module wo_order_stage
    import wo_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  wo_req_t head,
    input  logic    head_valid,
    output logic    pop,
    output wo_req_t mem_req,
    input  logic    mem_rd_full,
    input  logic    mem_wr_full,
    input  wo_rsp_t mem_rsp,
    output wo_rsp_t afu_rsp
);

    localparam int rd_tag_bits = $bits(wo_rd_tag_t);
    localparam int wr_tag_bits = $bits(wo_wr_tag_t);

    // ========================================
    // Issue slot
    // ========================================

    wo_req_t    slot;
    wo_req_t    slot_next;
    logic       split_done;
    logic       same_addr;
    logic       slot_active;
    logic       rd_blocked;
    logic       wr_blocked;
    logic       issue;
    logic       load;
    wo_hash_t   rd_hash;
    wo_hash_t   wr_hash;

    // Tracker results
    wo_rd_tag_t rd_alloc_tag;
    wo_wr_tag_t wr_alloc_tag;
    logic       rd_has_free;
    logic       wr_has_free;
    logic [0:0] rd_busy;
    logic [1:0] wr_busy;
    wo_rd_tag_t rd_saved_mdata;
    wo_wr_tag_t wr_saved_mdata;
    wo_rsp_t    rsp_restored;

    assign rd_hash = wo_hash_addr(slot.rd_addr);
    assign wr_hash = wo_hash_addr(slot.wr_addr);

    // A read and a write to one address in one slot go out as two slots.
    // The read is taken first without popping, then the write with the pop
    assign same_addr = head_valid && head.rd_valid && head.wr_valid &&
                       (head.rd_addr == head.wr_addr) && !split_done;

    always_comb
    begin
        slot_next = head;
        slot_next.rd_valid = head_valid && head.rd_valid && !split_done;
        slot_next.wr_valid = head_valid && head.wr_valid && !same_addr;
    end

    // Reads wait only on outstanding writes to their hash.
    // Writes wait on outstanding reads and writes to their hash
    assign rd_blocked = slot.rd_valid &&
                        (mem_rd_full || !rd_has_free ||
                         (slot.rd_check_order && wr_busy[0]));
    assign wr_blocked = slot.wr_valid &&
                        (mem_wr_full || !wr_has_free ||
                         (slot.wr_check_order && (rd_busy[0] || wr_busy[1])));

    // Both halves go together or neither goes, which keeps the channels in step
    assign slot_active = slot.rd_valid || slot.wr_valid;
    assign issue = slot_active && !rd_blocked && !wr_blocked;
    assign load = !slot_active || issue;
    assign pop = load && head_valid && !same_addr;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            slot.rd_valid <= 1'b0;
            slot.wr_valid <= 1'b0;
            split_done <= 1'b0;
        end
        else if (load)
        begin
            slot <= slot_next;
            if (head_valid)
            begin
                split_done <= same_addr;
            end
        end
    end

    // Low mdata bits go out as heap tags and the rest passes untouched
    always_comb
    begin
        mem_req = slot;
        mem_req.rd_valid = slot.rd_valid && issue;
        mem_req.wr_valid = slot.wr_valid && issue;
        mem_req.rd_mdata = {slot.rd_mdata[`WO_MDATA_BITS-1:rd_tag_bits], rd_alloc_tag};
        mem_req.wr_mdata = {slot.wr_mdata[`WO_MDATA_BITS-1:wr_tag_bits], wr_alloc_tag};
    end

    // ========================================
    // Tag trackers
    // ========================================

    // Only writes test against outstanding reads
    wo_tag_tracker #(
        .n_tags  (`WO_RD_TAGS),
        .n_tests (1)
    ) rd_tracker (
        .clk          (clk),
        .reset_n      (reset_n),
        .insert       (mem_req.rd_valid),
        .insert_hash  (rd_hash),
        .insert_mdata (slot.rd_mdata[rd_tag_bits-1:0]),
        .alloc_tag    (rd_alloc_tag),
        .has_free     (rd_has_free),
        .remove       (mem_rsp.rd_valid),
        .remove_tag   (mem_rsp.rd_mdata[rd_tag_bits-1:0]),
        .saved_mdata  (rd_saved_mdata),
        .test_hash    (wr_hash),
        .busy         (rd_busy)
    );

    // Test 0 serves the read half, test 1 the write half
    wo_tag_tracker #(
        .n_tags  (`WO_WR_TAGS),
        .n_tests (2)
    ) wr_tracker (
        .clk          (clk),
        .reset_n      (reset_n),
        .insert       (mem_req.wr_valid),
        .insert_hash  (wr_hash),
        .insert_mdata (slot.wr_mdata[wr_tag_bits-1:0]),
        .alloc_tag    (wr_alloc_tag),
        .has_free     (wr_has_free),
        .remove       (mem_rsp.wr_valid),
        .remove_tag   (mem_rsp.wr_mdata[wr_tag_bits-1:0]),
        .saved_mdata  (wr_saved_mdata),
        .test_hash    ({wr_hash, rd_hash}),
        .busy         (wr_busy)
    );

    // ========================================
    // Response restore
    // ========================================

    always_comb
    begin
        rsp_restored = mem_rsp;
        rsp_restored.rd_mdata = {mem_rsp.rd_mdata[`WO_MDATA_BITS-1:rd_tag_bits], rd_saved_mdata};
        rsp_restored.wr_mdata = {mem_rsp.wr_mdata[`WO_MDATA_BITS-1:wr_tag_bits], wr_saved_mdata};
    end

    // One register stage, with the saved bits read as the tag is freed
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            afu_rsp.rd_valid <= 1'b0;
            afu_rsp.wr_valid <= 1'b0;
        end
        else
        begin
            afu_rsp <= rsp_restored;
        end
    end

endmodule

// File: wo_tag_tracker.sv
// ========================================
// Tag heap and busy-hash table for one
// request channel: free-tag allocation,
// saved mdata bits per tag and the
// conflict test against live hashes
// ========================================

`timescale 1ns/1ps

module wo_tag_tracker
    import wo_pkg::*;
#(
    parameter int n_tags = 16,
    parameter int n_tests = 1
)
(
    input  logic                       clk,
    input  logic                       reset_n,

    // Allocation of a new tag when a request issues
    input  logic                       insert,
    input  wo_hash_t                   insert_hash,
    input  logic [$clog2(n_tags)-1:0]  insert_mdata,
    output logic [$clog2(n_tags)-1:0]  alloc_tag,
    output logic                       has_free,

    // Release of a tag when its response returns
    input  logic                       remove,
    input  logic [$clog2(n_tags)-1:0]  remove_tag,
    output logic [$clog2(n_tags)-1:0]  saved_mdata,

    // Conflict test ports
    input  wo_hash_t [n_tests-1:0]     test_hash,
    output logic [n_tests-1:0]         busy
);

    localparam int tag_bits = $clog2(n_tags);

    // One live bit per tag, which doubles as the heap's free bitmap
    logic [n_tags-1:0]   live;

    // Per-tag payload, meaningful only while the live bit is set
    logic [tag_bits-1:0] mdata_mem [n_tags];
    wo_hash_t            hash_mem [n_tags];

    assign has_free = !(&live);

    // Lowest free tag wins.
    // When the heap is exhausted the value is unused since insert stays low
    always_comb
    begin
        alloc_tag = '0;
        for (int i = n_tags - 1; i >= 0; i--)
        begin
            if (!live[i])
            begin
                alloc_tag = tag_bits'(i);
            end
        end
    end

    // The response path reads the saved bits in the cycle of its remove
    assign saved_mdata = mdata_mem[remove_tag];

    // A hash is busy when any live entry holds it.
    // The tables are registered so a fresh insert shows up one cycle later
    always_comb
    begin
        busy = '0;
        for (int t = 0; t < n_tests; t++)
        begin
            for (int i = 0; i < n_tags; i++)
            begin
                if (live[i] && (hash_mem[i] == test_hash[t]))
                begin
                    busy[t] = 1'b1;
                end
            end
        end
    end

    // Insert and remove never name the same tag in one cycle.
    // Insert takes a free tag while remove frees a live one
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            live <= '0;
        end
        else
        begin
            if (remove)
            begin
                live[remove_tag] <= 1'b0;
            end
            if (insert)
            begin
                live[alloc_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (insert)
        begin
            mdata_mem[alloc_tag] <= insert_mdata;
            hash_mem[alloc_tag] <= insert_hash;
        end
    end

endmodule

// File: wo_request_queue.sv
// ========================================
// Input buffer of the write-ordering shim
// Circular FIFO of request slots with a
// registered almost-full level
// ========================================

`timescale 1ns/1ps

`include "wo_params.svh"

module wo_request_queue
    import wo_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  wo_req_t req,
    input  logic    pop,
    output wo_req_t head,
    output logic    head_valid,
    output logic    almost_full
);

    localparam int depth = `WO_QUEUE_DEPTH;
    localparam int ptr_bits = $clog2(depth);
    localparam int count_bits = $clog2(depth + 1);

    // Occupancy at which only the threshold number of entries is left free
    localparam int af_level = depth - `WO_QUEUE_THRESHOLD;

    wo_req_t               entries [depth];
    logic [ptr_bits-1:0]   rd_ptr;
    logic [ptr_bits-1:0]   wr_ptr;
    logic [count_bits-1:0] count;
    logic [count_bits-1:0] count_next;
    logic                  push;

    // Any request with a live half takes an entry.
    // The source keeps the queue from overflowing by honoring almost_full
    assign push = req.rd_valid || req.wr_valid;

    // The oldest entry is presented straight from storage
    assign head = entries[rd_ptr];
    assign head_valid = (count != '0);

    always_comb
    begin
        count_next = count;
        if (push && !pop)
        begin
            count_next = count + 1'b1;
        end
        else if (!push && pop)
        begin
            count_next = count - 1'b1;
        end
    end

    // Payload storage, written at the tail
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            entries[wr_ptr] <= req;
        end
    end

    // Pointers wrap explicitly since the depth need not be a power of two
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
            almost_full <= 1'b0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (int'(wr_ptr) == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (int'(rd_ptr) == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            // Registered so the source sees a clean level
            almost_full <= (int'(count_next) >= af_level);
        end
    end

endmodule

// File: wo_pkg.sv
// ========================================
// Shared types of the write-ordering shim
// Hash and tag types, the request and
// response structs, and the address hash
// ========================================

`include "wo_params.svh"

package wo_pkg;

    // Folded address, the key of both conflict filters
    typedef logic [`WO_HASH_BITS-1:0] wo_hash_t;

    // Heap indices that replace the low bits of a request's mdata
    typedef logic [$clog2(`WO_RD_TAGS)-1:0] wo_rd_tag_t;
    typedef logic [$clog2(`WO_WR_TAGS)-1:0] wo_wr_tag_t;

    // One request slot with a read half and a write half.
    // On the memory side the low tag bits of each mdata carry the heap index
    typedef struct packed {
        logic                      rd_valid;
        logic [`WO_ADDR_BITS-1:0]  rd_addr;
        logic [`WO_MDATA_BITS-1:0] rd_mdata;
        logic                      rd_check_order;
        logic                      wr_valid;
        logic [`WO_ADDR_BITS-1:0]  wr_addr;
        logic [`WO_MDATA_BITS-1:0] wr_mdata;
        logic [`WO_DATA_BITS-1:0]  wr_data;
        logic                      wr_check_order;
    } wo_req_t;

    // Responses, reads with data and writes with mdata only
    typedef struct packed {
        logic                      rd_valid;
        logic [`WO_MDATA_BITS-1:0] rd_mdata;
        logic [`WO_DATA_BITS-1:0]  rd_data;
        logic                      wr_valid;
        logic [`WO_MDATA_BITS-1:0] wr_mdata;
    } wo_rsp_t;

    // Number of hash-wide slices needed to cover an address
    localparam int wo_hash_slices = (`WO_ADDR_BITS + `WO_HASH_BITS - 1) / `WO_HASH_BITS;

    // Fold the address by XOR of its successive hash-wide slices.
    // The top slice is padded with zeros when the widths do not divide
    function automatic wo_hash_t wo_hash_addr(input logic [`WO_ADDR_BITS-1:0] addr);
        logic [wo_hash_slices*`WO_HASH_BITS-1:0] padded;
        wo_hash_t                                folded;
        padded = '0;
        padded[`WO_ADDR_BITS-1:0] = addr;
        folded = '0;
        for (int i = 0; i < wo_hash_slices; i++)
        begin
            folded = folded ^ padded[i*`WO_HASH_BITS +: `WO_HASH_BITS];
        end
        return folded;
    endfunction

endpackage

// File: wo_params.svh
// ========================================
// Size definitions for the write-ordering
// shim: address, data and mdata widths,
// the address hash width, the tag heap
// sizes and the request queue depth
// ========================================

`ifndef WO_PARAMS_SVH
`define WO_PARAMS_SVH

// Byte address carried by each request half
`define WO_ADDR_BITS 32

// Write data and read response data width
`define WO_DATA_BITS 64

// Mdata travels with a request and comes back on its response
`define WO_MDATA_BITS 16

// Width of the folded address hash used by the conflict filters.
// Fewer bits save storage but raise the rate of false conflicts
`define WO_HASH_BITS 9

// Outstanding request limits, one tag heap entry per request in flight.
// Both must be powers of two so that every tag value names a heap entry
`define WO_RD_TAGS 16
`define WO_WR_TAGS 8

// Request queue entries and the free level at which almost-full rises
`define WO_QUEUE_DEPTH 6
`define WO_QUEUE_THRESHOLD 4

`endif
